// File: Makefile
# Verilator flow for the quadrature mixer testbench
# Any variable can be overridden, for example: make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= ddc_mixer_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/complex_mixer.sv
/* Rotates the sample by minus the oscillator phase at full precision.
   No rounding or saturation, results are OUT_W bits wide */
`timescale 1ns/10ps
`default_nettype none

module complex_mixer (
    input  logic          reset,
    input  logic          clk,
    input  logic          en,                      // Clock enable
    mix_stage_if.mix      operands,                // Sample and trig pair
    output dsp_pkg::out_t out_i,                   // I*cos + Q*sin
    output dsp_pkg::out_t out_q                    // Q*cos - I*sin
);

    // Stage 1 products
    logic signed [dsp_pkg::PROD_W-1:0] ic_reg;     // I * cos
    logic signed [dsp_pkg::PROD_W-1:0] qs_reg;     // Q * sin
    logic signed [dsp_pkg::PROD_W-1:0] qc_reg;     // Q * cos
    logic signed [dsp_pkg::PROD_W-1:0] is_reg;     // I * sin

    //--------------------------------------------------------------------------
    // Stage 1, four signed products
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ic_reg <= '0;
            qs_reg <= '0;
            qc_reg <= '0;
            is_reg <= '0;
        end else if (en) begin
            // Both operands signed, so signed multiply
            ic_reg <= operands.samp_i * operands.cos_val;
            qs_reg <= operands.samp_q * operands.sin_val;
            qc_reg <= operands.samp_q * operands.cos_val;
            is_reg <= operands.samp_i * operands.sin_val;
        end
    end

    //--------------------------------------------------------------------------
    // Stage 2, multiply by cos - j*sin
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_i <= '0;
            out_q <= '0;
        end else if (en) begin
            // Sign-extend before the add, one guard bit
            out_i <= dsp_pkg::out_t'(ic_reg) + dsp_pkg::out_t'(qs_reg);
            out_q <= dsp_pkg::out_t'(qc_reg) - dsp_pkg::out_t'(is_reg);
        end
    end

endmodule : complex_mixer

`default_nettype wire

// File: design/ddc_mixer_top.sv
/* Quadrature mixer, output 3 enabled edges after the input sample.
   en low holds every stage; freq_word change applies at the next edge */
`timescale 1ns/10ps
`default_nettype none

module ddc_mixer_top (
    input  logic             clk,
    input  logic             reset,                // Async, active high
    input  logic             en,                   // Advances all stages
    input  nco_pkg::freq_t   freq_word,            // Oscillator step
    input  dsp_pkg::sample_t in_i,
    input  dsp_pkg::sample_t in_q,
    output dsp_pkg::out_t    out_i,
    output dsp_pkg::out_t    out_q
);

    // Aligned sample and trig pair into the multiplier
    mix_stage_if stage_bus ();

    //--------------------------------------------------------------------------
    // Oscillator and sample delay run side by side
    //--------------------------------------------------------------------------
    nco nco0 (
        .reset     (reset),
        .clk       (clk),
        .en        (en),
        .freq_word (freq_word),
        .trig      (stage_bus.osc)
    );

    sample_align align0 (
        .reset   (reset),
        .clk     (clk),
        .en      (en),
        .in_i    (in_i),
        .in_q    (in_q),
        .aligned (stage_bus.align)
    );

    //--------------------------------------------------------------------------
    // Complex multiply
    //--------------------------------------------------------------------------
    complex_mixer mixer0 (
        .reset    (reset),
        .clk      (clk),
        .en       (en),
        .operands (stage_bus.mix),
        .out_i    (out_i),
        .out_q    (out_q)
    );

endmodule : ddc_mixer_top

`default_nettype wire

// File: design/dsp_pkg.sv
/* Sample and mixer result widths for the complex datapath.
   PROD_W takes the trig width from nco_pkg, so nco_pkg must compile first */
`default_nettype none

package dsp_pkg;

    //--------------------------------------------------------------------------
    // Complex input sample
    //--------------------------------------------------------------------------
    localparam int SAMPLE_W = 12;                        // Bits per I or Q word

    typedef logic signed [SAMPLE_W-1:0] sample_t;        // One I or Q sample

    //--------------------------------------------------------------------------
    // Multiplier and adder results
    //--------------------------------------------------------------------------
    // Full precision product of a sample and a trig value
    localparam int PROD_W = SAMPLE_W + $bits(nco_pkg::trig_t);

    // One extra bit so the sum of two products never wraps
    localparam int OUT_W = PROD_W + 1;

    typedef logic signed [OUT_W-1:0] out_t;              // One I or Q result

endpackage : dsp_pkg

`default_nettype wire

// File: design/mix_stage_if.sv
/* Aligned sample plus trig pair that feed the complex multiplier.
   Plain bundle with no handshake; every stage advances on the shared en */
`timescale 1ns/10ps
`default_nettype none

interface mix_stage_if;

    // Delayed complex sample
    dsp_pkg::sample_t samp_i;                      // In-phase part
    dsp_pkg::sample_t samp_q;                      // Quadrature part

    // Oscillator output for the same phase
    nco_pkg::trig_t   sin_val;
    nco_pkg::trig_t   cos_val;

    //--------------------------------------------------------------------------
    // Views for each block
    //--------------------------------------------------------------------------
    modport osc (                                  // Oscillator side
        output sin_val,
        output cos_val
    );

    modport align (                                // Sample delay line side
        output samp_i,
        output samp_q
    );

    modport mix (                                  // Multiplier reads all
        input  samp_i,
        input  samp_q,
        input  sin_val,
        input  cos_val
    );

endinterface : mix_stage_if

`default_nettype wire

// File: design/nco.sv
/* Phase accumulator feeding the sine/cosine table. Phase k*freq_word is
   sampled at enabled edge k and its trig pair appears after edge k+1 */
`timescale 1ns/10ps
`default_nettype none

module nco (
    input  logic           reset,
    input  logic           clk,
    input  logic           en,                     // Clock enable
    input  nco_pkg::freq_t freq_word,              // Phase step per edge
    mix_stage_if.osc       trig                    // Sine and cosine out
);

    nco_pkg::freq_t              acc_reg;          // Running phase
    nco_pkg::phase_t             phase;            // Top bits to the table
    logic [nco_pkg::PHASE_W-1:0] sin_raw;
    logic [nco_pkg::PHASE_W-1:0] cos_raw;

    //--------------------------------------------------------------------------
    // Phase accumulator
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_reg <= '0;                         // Phase restarts at zero
        end else if (en) begin
            acc_reg <= acc_reg + freq_word;        // Wraps mod 2**ACC_W
        end
    end

    // Truncated phase, no dither
    assign phase = acc_reg[nco_pkg::ACC_W-1 -: nco_pkg::PHASE_W];

    //--------------------------------------------------------------------------
    // Table lookup, two enabled edges deep
    //--------------------------------------------------------------------------
    rom_sin_cos #(
        .WIDTH   (nco_pkg::PHASE_W),
        .RAMTYPE ("AUTO")
    ) rom0 (
        .reset  (reset),
        .clk    (clk),
        .clkena (en),
        .arg    (phase),
        .sin    (sin_raw),
        .cos    (cos_raw)
    );

    // Table output is already two's complement
    assign trig.sin_val = nco_pkg::trig_t'(sin_raw);
    assign trig.cos_val = nco_pkg::trig_t'(cos_raw);

endmodule : nco

`default_nettype wire

// File: design/nco_pkg.sv
/* Oscillator widths. Phase sent to the table is the top PHASE_W bits of
   the accumulator, and the table covers one quadrant only */
`default_nettype none

package nco_pkg;

    //--------------------------------------------------------------------------
    // Phase accumulator
    //--------------------------------------------------------------------------
    localparam int ACC_W   = 24;                   // Accumulator width
    localparam int PHASE_W = 12;                   // Phase bits into the ROM

    typedef logic [ACC_W-1:0]          freq_t;     // Unsigned phase step
    typedef logic [PHASE_W-1:0]        phase_t;    // Full turn is 2**PHASE_W
    typedef logic signed [PHASE_W-1:0] trig_t;     // Sine or cosine word

    //--------------------------------------------------------------------------
    // Quarter-wave table
    //--------------------------------------------------------------------------
    localparam int LUT_AW    = PHASE_W - 2;        // Entries per quadrant, log2
    localparam int LUT_FW    = PHASE_W - 1;        // Magnitude bits, no sign
    localparam int TRIG_FULL = 2**LUT_FW - 1;      // Largest magnitude, 2047

endpackage : nco_pkg

`default_nettype wire

// File: design/rom_sin_cos.sv
/* Sine/cosine of arg with latency 2 clkena edges, WIDTH of 4 or more.
   Table filled at elaboration from $sin, truncated toward zero */
`timescale 1ns/10ps
`default_nettype none

module rom_sin_cos #(
    parameter int unsigned WIDTH   = 12,           // Argument and result width
    parameter string       RAMTYPE = "AUTO"        // Memory resource hint
) (
    input  logic             reset,
    input  logic             clk,
    input  logic             clkena,               // Advances both stages
    input  logic [WIDTH-1:0] arg,                  // Full turn is 2**WIDTH
    output logic [WIDTH-1:0] sin,                  // Two's complement
    output logic [WIDTH-1:0] cos                   // Two's complement
);

    localparam int unsigned AWIDTH  = WIDTH - 2;   // Quarter-wave address bits
    localparam int unsigned FWIDTH  = WIDTH - 1;   // Table magnitude bits
    localparam real         HALF_PI = 1.57079632679489661923;

    logic [1:0]        quad;                       // Quadrant of arg
    logic [AWIDTH-1:0] rem;                        // Offset inside quadrant
    logic              rem_zero;                   // Exactly on a corner

    // First stage, folded argument
    logic [AWIDTH-1:0] sin_addr_reg;
    logic [AWIDTH-1:0] cos_addr_reg;
    logic              sin_sign_reg;
    logic              cos_sign_reg;
    logic              sin_corr_reg;               // Force full scale
    logic              cos_corr_reg;

    logic [FWIDTH-1:0] sin_value;
    logic [FWIDTH-1:0] cos_value;

    //--------------------------------------------------------------------------
    // First quadrant sine table
    //--------------------------------------------------------------------------
    (* ramstyle = RAMTYPE *) logic [FWIDTH-1:0] lut [2**AWIDTH];

    initial begin
        for (int i = 0; i < 2**AWIDTH; i++) begin
            // Entry i is sin(i/2**AWIDTH of a quarter turn) at full scale
            lut[i] = FWIDTH'($rtoi($sin(real'(i) / real'(2**AWIDTH) * HALF_PI)
                                   * real'(2**FWIDTH - 1)));
        end
    end

    // Applies full-scale correction then negation
    function automatic logic [WIDTH-1:0] finish(input logic [FWIDTH-1:0] value,
                                                input logic              corr,
                                                input logic              neg);
        logic [FWIDTH-1:0] mag;
        mag = value | {FWIDTH{corr}};              // Corner entry is missing
        return {neg, (mag ^ {FWIDTH{neg}}) + {{FWIDTH-1{1'b0}}, neg}};
    endfunction

    assign quad     = arg[WIDTH-1 -: 2];
    assign rem      = arg[AWIDTH-1:0];
    assign rem_zero = (rem == '0);

    //--------------------------------------------------------------------------
    // Stage 1 folds the argument
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sin_addr_reg <= '0;
            cos_addr_reg <= '0;
            sin_sign_reg <= 1'b0;
            cos_sign_reg <= 1'b0;
            sin_corr_reg <= 1'b0;
            cos_corr_reg <= 1'b0;
        end else if (clkena) begin
            // Odd quadrants walk the table backwards, 2**AWIDTH - rem
            sin_addr_reg <= ({AWIDTH{quad[0]}} ^ rem) + {{AWIDTH-1{1'b0}}, quad[0]};
            // Cosine is a quarter turn ahead, so even quadrants mirror
            cos_addr_reg <= ({AWIDTH{~quad[0]}} ^ rem) + {{AWIDTH-1{1'b0}}, ~quad[0]};
            // Lower half turn negative, except the zero at half turn
            sin_sign_reg <= quad[1] & (quad[0] | ~rem_zero);
            cos_sign_reg <= ((quad == 2'b01) & ~rem_zero) | (quad == 2'b10);
            // Peak lands one past the last table entry
            sin_corr_reg <= quad[0] & rem_zero;
            cos_corr_reg <= ~quad[0] & rem_zero;
        end
    end

    // Registered address read
    assign sin_value = lut[sin_addr_reg];
    assign cos_value = lut[cos_addr_reg];

    //--------------------------------------------------------------------------
    // Stage 2 applies correction and sign
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sin <= '0;
            cos <= '0;
        end else if (clkena) begin
            sin <= finish(sin_value, sin_corr_reg, sin_sign_reg);
            cos <= finish(cos_value, cos_corr_reg, cos_sign_reg);
        end
    end

endmodule : rom_sin_cos

`default_nettype wire

// File: design/sample_align.sv
/* Two-deep delay of the complex sample, equal to the table latency,
   so each sample meets the trig pair of its own phase */
`timescale 1ns/10ps
`default_nettype none

module sample_align (
    input  logic             reset,
    input  logic             clk,
    input  logic             en,                   // Clock enable
    input  dsp_pkg::sample_t in_i,
    input  dsp_pkg::sample_t in_q,
    mix_stage_if.align       aligned               // Delayed sample out
);

    // Matches argument fold stage
    dsp_pkg::sample_t s1_i;
    dsp_pkg::sample_t s1_q;
    // Matches table output stage
    dsp_pkg::sample_t s2_i;
    dsp_pkg::sample_t s2_q;

    //--------------------------------------------------------------------------
    // Delay line
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_i <= '0;
            s1_q <= '0;
            s2_i <= '0;
            s2_q <= '0;
        end else if (en) begin
            s1_i <= in_i;                          // Captured with its phase
            s1_q <= in_q;
            s2_i <= s1_i;                          // Lines up with sin/cos
            s2_q <= s1_q;
        end
    end

    assign aligned.samp_i = s2_i;
    assign aligned.samp_q = s2_q;

endmodule : sample_align

`default_nettype wire

// File: project.f
design/nco_pkg.sv
design/dsp_pkg.sv
design/mix_stage_if.sv
design/rom_sin_cos.sv
design/nco.sv
design/sample_align.sv
design/complex_mixer.sv
design/ddc_mixer_top.sv
tests/ddc_mixer_assert.sv
tests/ddc_mixer_tb.sv

// File: tests/ddc_mixer_assert.sv
/* Port checks bound into ddc_mixer_top. Hold check is off during reset,
   zero check needs reset high at two edges in a row */
`timescale 1ns/10ps
`default_nettype none

module ddc_mixer_assert (
    input logic          clk,
    input logic          reset,
    input logic          en,
    input dsp_pkg::out_t out_i,
    input dsp_pkg::out_t out_q
);

    //--------------------------------------------------------------------------
    // Stall and reset behavior
    //--------------------------------------------------------------------------
    // en low at the last edge, so nothing moved
    property hold_when_stalled;
        @(posedge clk) disable iff (reset)
            !$past(en) |-> ($stable(out_i) && $stable(out_q));
    endproperty

    property zero_in_reset;
        @(posedge clk) (reset && $past(reset)) |-> (out_i == '0 && out_q == '0);
    endproperty

    hold_a: assert property (hold_when_stalled)
        else $error("Mixer output changed while en was low");

    reset_a: assert property (zero_in_reset)
        else $error("Mixer output not zero during reset");

endmodule : ddc_mixer_assert

bind ddc_mixer_top ddc_mixer_assert assert0 (
    .clk   (clk),
    .reset (reset),
    .en    (en),
    .out_i (out_i),
    .out_q (out_q)
);

`default_nettype wire

// File: tests/ddc_mixer_tb.sv
/* Directed tests of the quadrature mixer against a quarter-wave table model.
   Inputs change 1 ns after the rising edge and outputs are checked there */
`timescale 1ns/10ps
`default_nettype none

module ddc_mixer_tb;

    localparam int  CLK_PERIOD   = 4;
    localparam int  RESET_CYCLES = 5;
    localparam int  N_FIXED      = 8;                  // Phase zero and corner tests
    localparam int  N_RANDOM     = 200;
    localparam int  N_STALL      = 150;                // Enabled edges in stall test
    localparam int  MAX_STALL    = 8;                  // Longest en low span
    localparam int  FLUSH        = 3;                  // Samples in flight
    // Worst case has a full stall span after every stall-test edge
    localparam int  TOTAL_CYCLES = 5 * (RESET_CYCLES + FLUSH) + FLUSH + 2 * N_FIXED
                                   + N_RANDOM + N_STALL * (1 + MAX_STALL);
    localparam real HALF_PI      = 1.57079632679489661923;
    localparam int  FIXED [N_FIXED] = '{2047, -2048, 1, -1, 0, 1234, -777, 512};

    logic             clk;
    logic             reset;
    logic             en;
    nco_pkg::freq_t   freq_word;
    dsp_pkg::sample_t in_i;
    dsp_pkg::sample_t in_q;
    dsp_pkg::out_t    out_i;
    dsp_pkg::out_t    out_q;

    logic [31:0]      lfsr_state;
    int               quarter [2**nco_pkg::LUT_AW];    // First quadrant sine
    nco_pkg::freq_t   model_acc;                       // Model phase accumulator
    dsp_pkg::out_t    pend_i [$];                      // Expected, oldest first
    dsp_pkg::out_t    pend_q [$];
    dsp_pkg::out_t    last_i;                          // Newest expected result
    dsp_pkg::out_t    last_q;

    ddc_mixer_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .freq_word (freq_word),
        .in_i      (in_i),
        .in_q      (in_q),
        .out_i     (out_i),
        .out_q     (out_q)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //--------------------------------------------------------------------------
    // Stimulus source and reference model
    //--------------------------------------------------------------------------
    // Right-shift Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);        // One step per bit
            bits[b]    = lfsr_state[0];
        end
        return bits;
    endfunction

    // Forces the most negative value now and then
    function automatic dsp_pkg::sample_t rand_sample();
        if (take_bits(3) == 0)
            return dsp_pkg::sample_t'(-2048);
        return dsp_pkg::sample_t'(take_bits(dsp_pkg::SAMPLE_W));
    endfunction

    // Quadrant folding of the quarter-wave table
    function automatic int model_sin(input nco_pkg::phase_t p);
        logic [1:0]                 quad;
        logic [nco_pkg::LUT_AW-1:0] r;
        logic [nco_pkg::LUT_AW-1:0] addr;
        int                         mag;
        quad = p[nco_pkg::PHASE_W-1 -: 2];
        r    = p[nco_pkg::LUT_AW-1:0];
        addr = quad[0] ? -r : r;                       // Odd quadrants use 1024 - r
        if (r == 0)
            mag = quad[0] ? nco_pkg::TRIG_FULL : 0;    // Corner values
        else
            mag = quarter[addr];
        return quad[1] ? -mag : mag;
    endfunction

    // Expected pair for a sample entering at the current model phase
    function automatic void push_expected(input dsp_pkg::sample_t si,
                                          input dsp_pkg::sample_t sq);
        nco_pkg::phase_t p;
        int              s;
        int              c;
        p = model_acc[nco_pkg::ACC_W-1 -: nco_pkg::PHASE_W];
        s = model_sin(p);
        c = model_sin(p + 12'd1024);                   // Quarter turn ahead
        pend_i.push_back(dsp_pkg::out_t'(int'(si) * c + int'(sq) * s));
        pend_q.push_back(dsp_pkg::out_t'(int'(sq) * c - int'(si) * s));
    endfunction

    task automatic check_out(input string name, input dsp_pkg::out_t expected,
                             input dsp_pkg::out_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "Mixer output mismatch");
        end
    endtask

    //--------------------------------------------------------------------------
    // Drivers
    //--------------------------------------------------------------------------
    task automatic step(input logic en_val, input dsp_pkg::sample_t si,
                        input dsp_pkg::sample_t sq);
        en   = en_val;
        in_i = si;
        in_q = sq;
        if (en_val)
            push_expected(si, sq);
        @(posedge clk);
        #1;
        if (en_val) begin
            model_acc = model_acc + freq_word;         // Step used at this edge
            last_i    = pend_i.pop_front();
            last_q    = pend_q.pop_front();
        end
        // With en low the previous result must hold
        check_out("out_i", last_i, out_i);
        check_out("out_q", last_q, out_q);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        en    = 1'b0;
        in_i  = '0;
        in_q  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset     = 1'b0;
        model_acc = '0;
        last_i    = '0;
        last_q    = '0;
        pend_i.delete();
        pend_q.delete();
        repeat (FLUSH) begin
            pend_i.push_back('0);                      // Cleared pipeline contents
            pend_q.push_back('0);
        end
        check_out("out_i", '0, out_i);
        check_out("out_q", '0, out_q);
    endtask

    task automatic flush();
        repeat (FLUSH) step(1'b1, '0, '0);
    endtask

    //--------------------------------------------------------------------------
    // Tests
    //--------------------------------------------------------------------------
    task automatic test_reset_state();
        apply_reset();
        freq_word = 24'h123456;
        repeat (FLUSH) step(1'b1, dsp_pkg::sample_t'(1000), dsp_pkg::sample_t'(-1000));
        flush();
    endtask

    // Quarter turn per edge when step is 2**22
    task automatic test_fixed(input nco_pkg::freq_t step_word);
        apply_reset();
        freq_word = step_word;
        for (int n = 0; n < N_FIXED; n++) begin
            step(1'b1, dsp_pkg::sample_t'(FIXED[n]), dsp_pkg::sample_t'(FIXED[N_FIXED-1-n]));
        end
        flush();
    endtask

    task automatic test_random();
        apply_reset();
        freq_word = nco_pkg::freq_t'(take_bits(nco_pkg::ACC_W));
        for (int n = 0; n < N_RANDOM; n++) begin
            if (n % 50 == 49)
                freq_word = nco_pkg::freq_t'(take_bits(nco_pkg::ACC_W));
            step(1'b1, rand_sample(), rand_sample());
        end
        flush();
    endtask

    task automatic test_stall();
        int span;
        apply_reset();
        freq_word = nco_pkg::freq_t'(take_bits(nco_pkg::ACC_W));
        for (int n = 0; n < N_STALL; n++) begin
            step(1'b1, rand_sample(), rand_sample());
            if (take_bits(3) == 0) begin
                span = int'(take_bits(3)) + 1;
                repeat (span) step(1'b0, rand_sample(), rand_sample());  // Ignored
            end
        end
        flush();
    endtask

    initial begin
        #((TOTAL_CYCLES + 100) * CLK_PERIOD);
        $display("Timeout, the tests did not finish in time");
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        en         = 1'b0;
        freq_word  = '0;
        in_i       = '0;
        in_q       = '0;
        lfsr_state = 32'h45ea6e19;
        for (int i = 0; i < 2**nco_pkg::LUT_AW; i++) begin
            quarter[i] = $rtoi($sin(real'(i) / real'(2**nco_pkg::LUT_AW) * HALF_PI)
                               * real'(nco_pkg::TRIG_FULL));   // Truncated toward zero
        end
        test_reset_state();
        test_fixed('0);                                // Phase stays at zero
        test_fixed(24'h400000);                        // Quadrant corners
        test_random();
        test_stall();
        $display("Verification passed");
        $finish;
    end

endmodule : ddc_mixer_tb

`default_nettype wire
